/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_traffic_controller
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

# Output goes to the terminal; the status comes from the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

/* project.f */
+incdir+include
src/tc_cfg_pkg.sv
src/tc_stream_pkg.sv
src/tc_csr_regs.sv
src/pfc_prio_timer.sv
src/pfc_pause_encode.sv
src/tc_packet_gen.sv
src/tc_packet_chk.sv
src/traffic_controller_top.sv
tests/tb_traffic_controller.sv

/* src/pfc_pause_encode.sv */
// PFC sideband encoder.
// Pause outputs lag the timer states by one register stage.
// Bit 0 of the link pause is XOFF, bit 1 an XON pulse when all clear.
`timescale 1ns/1ps

module pfc_pause_encode (
   input  logic                             tx_clk_156,
   input  logic                             tx_rst_n,
   input  logic [tc_cfg_pkg::PFC_PRIOS-1:0] i_prio_active,
   input  tc_cfg_pkg::pfc_prio_t            i_tx_class,
   output logic [tc_cfg_pkg::PFC_PRIOS-1:0] o_pfc_pause_data,
   output logic [1:0]                       o_pause_data,
   output logic                             o_gen_hold
);

   import tc_cfg_pkg::*;

   logic [PFC_PRIOS-1:0] pfc_q;
   logic                 any_q;     // XOFF level
   logic                 any_next;
   logic                 xon_q;

   assign any_q    = |pfc_q;
   assign any_next = |i_prio_active;

   always_ff @(posedge tx_clk_156) begin
      if (!tx_rst_n) begin
         pfc_q <= '0;
         xon_q <= 1'b0;
      end else begin
         pfc_q <= i_prio_active;
         xon_q <= any_q && !any_next; // Falls with the last active priority
      end
   end

   assign o_pfc_pause_data = pfc_q;
   assign o_pause_data     = {xon_q, any_q};
   assign o_gen_hold       = pfc_q[i_tx_class]; // Pause state of the generator's class

endmodule

/* src/pfc_prio_timer.sv */
// Pause timer for one priority.
// Active is high for exactly quanta cycles after the load cycle.
// A load with quanta 0 ends a running pause.
`timescale 1ns/1ps

module pfc_prio_timer (
   input  logic                    tx_clk_156,
   input  logic                    tx_rst_n,
   input  logic                    i_load,
   input  tc_cfg_pkg::pfc_quanta_t i_quanta,
   output logic                    o_active
);

   import tc_cfg_pkg::*;

   pfc_quanta_t count; // Cycles of pause left

   always_ff @(posedge tx_clk_156) begin
      if (!tx_rst_n)
         count <= '0;
      else if (i_load)
         count <= i_quanta;    // A new load restarts the pause
      else if (count != '0)
         count <= count - 1'b1;
   end

   assign o_active = (count != '0);

endmodule

/* src/tc_cfg_pkg.sv */
// Configuration package for the traffic controller.
// Register map, CSR types, PFC widths and counter widths.
// All CSR addresses are word addresses; unmapped ones read zero.
package tc_cfg_pkg;

   typedef logic [15:0] csr_addr_t;
   typedef logic [31:0] csr_data_t;

   // ------------------------------------------------------------------
   // Register map
   // ------------------------------------------------------------------
   localparam csr_addr_t REG_CTRL            = 16'h0000; // Write only
   localparam csr_addr_t REG_PKT_COUNT       = 16'h0001;
   localparam csr_addr_t REG_PKT_BEATS       = 16'h0002; // 1 to 255
   localparam csr_addr_t REG_TX_CLASS        = 16'h0003;
   localparam csr_addr_t REG_STAT_TX         = 16'h0004;
   localparam csr_addr_t REG_STAT_RX_GOOD    = 16'h0005;
   localparam csr_addr_t REG_STAT_RX_BAD     = 16'h0006;
   localparam csr_addr_t REG_STATUS          = 16'h0007;
   localparam csr_addr_t REG_PFC_QUANTA_BASE = 16'h0010; // Eight words, one per priority

   // Bit positions
   localparam int CTRL_START_BIT  = 0;
   localparam int CTRL_CLEAR_BIT  = 1;
   localparam int STATUS_BUSY_BIT = 0;

   // ------------------------------------------------------------------
   // PFC and counters
   // ------------------------------------------------------------------
   localparam int PFC_PRIOS = 8;

   typedef logic [15:0] pfc_quanta_t; // Pause time in clock cycles
   typedef logic [2:0]  pfc_prio_t;
   typedef logic [31:0] pkt_count_t;
   typedef logic [7:0]  beat_count_t;

endpackage

/* src/tc_csr_regs.sv */
// CSR block on tx_clk_156.
// Strobes last one cycle, ack pulses one cycle later. Read data is valid
// with the ack and held until the next read.
// The master must not strobe again before the ack.
// Start and quanta load are decoded straight from the write strobe.
`timescale 1ns/1ps

module tc_csr_regs (
   input  logic                    tx_clk_156,
   input  logic                    tx_rst_n,
   input  logic                    i_csr_read,
   input  logic                    i_csr_write,
   input  tc_cfg_pkg::csr_addr_t   i_csr_address,
   input  tc_cfg_pkg::csr_data_t   i_csr_writedata,
   input  logic                    i_tx_sent,
   input  logic                    i_gen_busy,
   input  logic                    i_rx_good,
   input  logic                    i_rx_bad,
   output tc_cfg_pkg::csr_data_t   o_csr_readdata,
   output logic                    o_csr_ack,
   output logic                    o_gen_start,
   output tc_cfg_pkg::pkt_count_t  o_pkt_count,
   output tc_cfg_pkg::beat_count_t o_pkt_beats,
   output tc_cfg_pkg::pfc_prio_t   o_tx_class,
   output logic [tc_cfg_pkg::PFC_PRIOS-1:0] o_pfc_load,
   output tc_cfg_pkg::pfc_quanta_t o_pfc_quanta
);

   import tc_cfg_pkg::*;

   pfc_quanta_t quanta_q [PFC_PRIOS]; // Readback copy of each priority's quanta
   pkt_count_t  stat_tx;
   pkt_count_t  stat_rx_good;
   pkt_count_t  stat_rx_bad;
   csr_data_t   rd_mux;
   pfc_prio_t   quanta_sel;
   logic        is_quanta;
   logic        ctrl_wr;
   logic        clear;

   // ------------------------------------------------------------------
   // Decode
   // ------------------------------------------------------------------
   assign is_quanta   = (i_csr_address[15:3] == REG_PFC_QUANTA_BASE[15:3]);
   assign quanta_sel  = i_csr_address[2:0];
   assign ctrl_wr     = i_csr_write && (i_csr_address == REG_CTRL);
   assign clear       = ctrl_wr && i_csr_writedata[CTRL_CLEAR_BIT];
   assign o_gen_start = ctrl_wr && i_csr_writedata[CTRL_START_BIT] && !i_gen_busy;

   // One-hot load, all timers share the quanta bus
   assign o_pfc_quanta = i_csr_writedata[15:0];
   always_comb begin
      o_pfc_load = '0;
      if (i_csr_write && is_quanta)
         o_pfc_load[quanta_sel] = 1'b1;
   end

   // Configuration registers
   always_ff @(posedge tx_clk_156) begin
      if (!tx_rst_n) begin
         o_pkt_count <= '0;
         o_pkt_beats <= 8'd1;
         o_tx_class  <= '0;
         for (int i = 0; i < PFC_PRIOS; i++)
            quanta_q[i] <= '0;
      end else if (i_csr_write) begin
         case (i_csr_address)
            REG_PKT_COUNT: o_pkt_count <= i_csr_writedata;
            REG_PKT_BEATS: o_pkt_beats <= i_csr_writedata[7:0];
            REG_TX_CLASS:  o_tx_class  <= i_csr_writedata[2:0];
            default: ;
         endcase
         if (is_quanta)
            quanta_q[quanta_sel] <= i_csr_writedata[15:0];
      end
   end

   // ------------------------------------------------------------------
   // Statistics counters
   // ------------------------------------------------------------------
   always_ff @(posedge tx_clk_156) begin
      if (!tx_rst_n || clear) begin
         stat_tx      <= '0;
         stat_rx_good <= '0;
         stat_rx_bad  <= '0;
      end else begin
         if (i_tx_sent) stat_tx      <= stat_tx + 1'b1;
         if (i_rx_good) stat_rx_good <= stat_rx_good + 1'b1;
         if (i_rx_bad)  stat_rx_bad  <= stat_rx_bad + 1'b1;
      end
   end

   // ------------------------------------------------------------------
   // Read path and ack
   // ------------------------------------------------------------------
   always_comb begin
      rd_mux = '0;
      case (i_csr_address)
         REG_PKT_COUNT:    rd_mux = o_pkt_count;
         REG_PKT_BEATS:    rd_mux = 32'(o_pkt_beats);
         REG_TX_CLASS:     rd_mux = 32'(o_tx_class);
         REG_STAT_TX:      rd_mux = stat_tx;
         REG_STAT_RX_GOOD: rd_mux = stat_rx_good;
         REG_STAT_RX_BAD:  rd_mux = stat_rx_bad;
         REG_STATUS:       rd_mux[STATUS_BUSY_BIT] = i_gen_busy;
         default: if (is_quanta) rd_mux = 32'(quanta_q[quanta_sel]);
      endcase
   end

   always_ff @(posedge tx_clk_156) begin
      if (!tx_rst_n) begin
         o_csr_ack      <= 1'b0;
         o_csr_readdata <= '0;
      end else begin
         o_csr_ack <= i_csr_read | i_csr_write;
         if (i_csr_read)
            o_csr_readdata <= rd_mux; // Held until the next read
      end
   end

endmodule

/* src/tc_packet_chk.sv */
// Packet checker for the 64-bit RX stream.
// Ready is always high. One good or bad pulse per eop beat, a cycle later.
// The packet number comes from the sop beat and is not checked for order.
`timescale 1ns/1ps

module tc_packet_chk (
   input  logic                     tx_clk_156,
   input  logic                     tx_rst_n,
   input  logic                     i_rx_valid,
   input  tc_stream_pkg::eth_beat_t i_rx_beat,
   output logic                     o_rx_ready,
   output logic                     o_good,
   output logic                     o_bad
);

   import tc_cfg_pkg::*;
   import tc_stream_pkg::*;

   beat_count_t exp_idx;  // Expected beat index
   pkt_count_t  pkt_num;
   logic        first;
   logic        pkt_bad;  // Sticky within a packet
   logic        beat_bad;

   assign o_rx_ready = 1'b1;
   assign first      = (exp_idx == '0);

   always_comb begin
      beat_bad = (i_rx_beat.sop != first) || i_rx_beat.error;
      if (i_rx_beat.data[31:0] != {24'd0, exp_idx})
         beat_bad = 1'b1;
      if (!first && i_rx_beat.data[63:32] != pkt_num)
         beat_bad = 1'b1;
      if (i_rx_beat.eop && i_rx_beat.empty != '0)
         beat_bad = 1'b1;
   end

   always_ff @(posedge tx_clk_156) begin
      if (i_rx_valid && first)
         pkt_num <= i_rx_beat.data[63:32];
   end

   always_ff @(posedge tx_clk_156) begin
      if (!tx_rst_n) begin
         exp_idx <= '0;
         pkt_bad <= 1'b0;
         o_good  <= 1'b0;
         o_bad   <= 1'b0;
      end else begin
         o_good <= 1'b0;
         o_bad  <= 1'b0;
         if (i_rx_valid) begin
            if (i_rx_beat.eop) begin
               exp_idx <= '0;
               pkt_bad <= 1'b0;
               o_good  <= !(pkt_bad || beat_bad);
               o_bad   <= pkt_bad || beat_bad;
            end else begin
               exp_idx <= exp_idx + 1'b1;
               pkt_bad <= pkt_bad || beat_bad;
            end
         end
      end
   end

endmodule

/* src/tc_packet_gen.sv */
// Packet generator for the 64-bit TX stream.
// Count and beats are latched at start; a start with count 0 is ignored.
// Hold is sampled only before valid rises, a presented beat stays put.
// One idle cycle separates packets; empty and error are always 0.
`timescale 1ns/1ps

module tc_packet_gen (
   input  logic                     tx_clk_156,
   input  logic                     tx_rst_n,
   input  logic                     i_start,
   input  tc_cfg_pkg::pkt_count_t   i_pkt_count,
   input  tc_cfg_pkg::beat_count_t  i_pkt_beats,
   input  logic                     i_hold,
   input  logic                     i_tx_ready,
   output logic                     o_tx_valid,
   output tc_stream_pkg::eth_beat_t o_tx_beat,
   output logic                     o_sent,
   output logic                     o_busy
);

   import tc_cfg_pkg::*;
   import tc_stream_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SEND,
      ST_GAP
   } gen_state_t;

   gen_state_t  state;
   pkt_count_t  pkt_total;
   pkt_count_t  pkt_idx;
   beat_count_t beat_total;
   beat_count_t beat_idx;
   logic        last_beat;
   logic        last_pkt;

   assign last_beat = (beat_idx == beat_total - 8'd1);
   assign last_pkt  = (pkt_idx == pkt_total - 32'd1);

   // Beat built from the indices by the payload rule
   always_comb begin
      o_tx_beat      = '0;
      o_tx_beat.data = {pkt_idx, 24'd0, beat_idx};
      o_tx_beat.sop  = (beat_idx == '0);
      o_tx_beat.eop  = last_beat;
   end

   assign o_sent = o_tx_valid && i_tx_ready && last_beat;
   assign o_busy = (state != ST_IDLE);

   // Sizes for the current run
   always_ff @(posedge tx_clk_156) begin
      if (state == ST_IDLE && i_start) begin
         pkt_total  <= i_pkt_count;
         beat_total <= i_pkt_beats;
      end
   end

   // ------------------------------------------------------------------
   // FSM
   // ------------------------------------------------------------------
   always_ff @(posedge tx_clk_156) begin
      if (!tx_rst_n) begin
         state      <= ST_IDLE;
         o_tx_valid <= 1'b0;
         pkt_idx    <= '0;
         beat_idx   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_start && i_pkt_count != '0) begin
                  state      <= ST_SEND;
                  o_tx_valid <= !i_hold;
                  pkt_idx    <= '0;
                  beat_idx   <= '0;
               end
            end
            ST_SEND: begin
               if (!o_tx_valid) begin
                  o_tx_valid <= !i_hold;    // Waiting out a pause
               end else if (i_tx_ready) begin
                  if (last_beat) begin
                     o_tx_valid <= 1'b0;
                     beat_idx   <= '0;
                     if (last_pkt) begin
                        state <= ST_IDLE;
                     end else begin
                        pkt_idx <= pkt_idx + 1'b1;
                        state   <= ST_GAP;
                     end
                  end else begin
                     beat_idx   <= beat_idx + 1'b1;
                     o_tx_valid <= !i_hold;
                  end
               end
            end
            ST_GAP: begin
               state      <= ST_SEND;
               o_tx_valid <= !i_hold;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* src/tc_stream_pkg.sv */
// Stream package for the 64-bit packet port.
// Payload rule: upper 32 data bits hold the packet number, lower 32 bits
// the beat index. Last beat has empty 0, error is 0 on every beat.
package tc_stream_pkg;

   typedef logic [63:0] eth_data_t;
   typedef logic [2:0]  eth_empty_t; // Unused bytes on the eop beat

   // One beat of the stream, valid travels beside it
   typedef struct packed {
      eth_data_t  data;
      logic       sop;
      logic       eop;
      eth_empty_t empty;
      logic       error;
   } eth_beat_t;

endpackage

/* src/traffic_controller_top.sv */
// Traffic controller top level, single clock tx_clk_156.
// RX is assumed on the TX clock, as in a loopback.
// The 6-bit MAC RX error is ORed into the beat's error bit.
`timescale 1ns/1ps

module traffic_controller_top (
   input  logic                     tx_clk_156,
   input  logic                     tx_rst_n,
   // TX stream
   output logic                     o_tx_valid,
   output tc_stream_pkg::eth_beat_t o_tx_beat,
   input  logic                     i_tx_ready,
   // RX stream
   input  logic                     i_rx_valid,
   input  tc_stream_pkg::eth_beat_t i_rx_beat,
   input  logic [5:0]               i_rx_error,
   output logic                     o_rx_ready,
   // CSR
   input  logic                     i_csr_read,
   input  logic                     i_csr_write,
   input  tc_cfg_pkg::csr_addr_t    i_csr_address,
   input  tc_cfg_pkg::csr_data_t    i_csr_writedata,
   output tc_cfg_pkg::csr_data_t    o_csr_readdata,
   output logic                     o_csr_ack,
   // MAC sideband
   output logic [1:0]               o_pause_data,
   output logic [7:0]               o_pfc_pause_data
);

   import tc_cfg_pkg::*;
   import tc_stream_pkg::*;

   pkt_count_t           pkt_count;
   beat_count_t          pkt_beats;
   pfc_prio_t            tx_class;
   pfc_quanta_t          pfc_quanta;
   logic [PFC_PRIOS-1:0] pfc_load;
   logic [PFC_PRIOS-1:0] prio_active;
   logic                 gen_start;
   logic                 gen_hold;
   logic                 gen_busy;
   logic                 tx_sent;
   logic                 rx_good;
   logic                 rx_bad;
   eth_beat_t            rx_beat;

   always_comb begin
      rx_beat       = i_rx_beat;
      rx_beat.error = i_rx_beat.error || (|i_rx_error);
   end

   tc_csr_regs u_csr (
      .tx_clk_156      (tx_clk_156),
      .tx_rst_n        (tx_rst_n),
      .i_csr_read      (i_csr_read),
      .i_csr_write     (i_csr_write),
      .i_csr_address   (i_csr_address),
      .i_csr_writedata (i_csr_writedata),
      .i_tx_sent       (tx_sent),
      .i_gen_busy      (gen_busy),
      .i_rx_good       (rx_good),
      .i_rx_bad        (rx_bad),
      .o_csr_readdata  (o_csr_readdata),
      .o_csr_ack       (o_csr_ack),
      .o_gen_start     (gen_start),
      .o_pkt_count     (pkt_count),
      .o_pkt_beats     (pkt_beats),
      .o_tx_class      (tx_class),
      .o_pfc_load      (pfc_load),
      .o_pfc_quanta    (pfc_quanta)
   );

   // ------------------------------------------------------------------
   // Priority flow control
   // ------------------------------------------------------------------
   for (genvar gi = 0; gi < PFC_PRIOS; gi++) begin : g_prio
      pfc_prio_timer u_timer (
         .tx_clk_156 (tx_clk_156),
         .tx_rst_n   (tx_rst_n),
         .i_load     (pfc_load[gi]),
         .i_quanta   (pfc_quanta),
         .o_active   (prio_active[gi])
      );
   end

   pfc_pause_encode u_pause (
      .tx_clk_156       (tx_clk_156),
      .tx_rst_n         (tx_rst_n),
      .i_prio_active    (prio_active),
      .i_tx_class       (tx_class),
      .o_pfc_pause_data (o_pfc_pause_data),
      .o_pause_data     (o_pause_data),
      .o_gen_hold       (gen_hold)
   );

   // ------------------------------------------------------------------
   // Generator and checker
   // ------------------------------------------------------------------
   tc_packet_gen u_gen (
      .tx_clk_156  (tx_clk_156),
      .tx_rst_n    (tx_rst_n),
      .i_start     (gen_start),
      .i_pkt_count (pkt_count),
      .i_pkt_beats (pkt_beats),
      .i_hold      (gen_hold),
      .i_tx_ready  (i_tx_ready),
      .o_tx_valid  (o_tx_valid),
      .o_tx_beat   (o_tx_beat),
      .o_sent      (tx_sent),
      .o_busy      (gen_busy)
   );

   tc_packet_chk u_chk (
      .tx_clk_156 (tx_clk_156),
      .tx_rst_n   (tx_rst_n),
      .i_rx_valid (i_rx_valid),
      .i_rx_beat  (rx_beat),
      .o_rx_ready (o_rx_ready),
      .o_good     (rx_good),
      .o_bad      (rx_bad)
   );

endmodule

/* include/tb_tc_vectors.svh */
// Stimulus and expected counter values for the traffic controller testbench.
// Included inside the testbench module, after the package imports.
// A corrupt index of all ones leaves every packet intact.
// Quanta 0 means no pause is written for that entry.
`ifndef TB_TC_VECTORS_SVH
`define TB_TC_VECTORS_SVH

// Columns: packets, beats, class, pause priority, quanta,
// corrupt packet, expected good, expected bad
typedef struct packed {
   pkt_count_t  pkt_count;
   beat_count_t beats;
   pfc_prio_t   cls;
   pfc_prio_t   pause_prio;
   pfc_quanta_t quanta;
   pkt_count_t  corrupt_pkt;
   pkt_count_t  exp_good;
   pkt_count_t  exp_bad;
} vector_entry_t;

localparam int NUM_VECTORS = 5;

localparam vector_entry_t VECTORS [NUM_VECTORS] = '{
   '{32'd4, 8'd3,  3'd0, 3'd0, 16'd0,  32'hFFFF_FFFF, 32'd4, 32'd0},
   '{32'd6, 8'd1,  3'd2, 3'd0, 16'd0,  32'd2,         32'd5, 32'd1},
   '{32'd5, 8'd4,  3'd3, 3'd3, 16'd40, 32'hFFFF_FFFF, 32'd5, 32'd0}, // Own class paused
   '{32'd8, 8'd2,  3'd1, 3'd5, 16'd50, 32'hFFFF_FFFF, 32'd8, 32'd0}, // Other class paused
   '{32'd3, 8'd16, 3'd7, 3'd0, 16'd0,  32'd1,         32'd2, 32'd1}
};

`endif

/* tests/tb_traffic_controller.sv */
// Testbench for the traffic controller.
// TX is looped back to RX through one register.
// Random back-pressure on TX ready; one data bit can be flipped on a chosen packet.
// Each table entry clears the counters, configures, starts and checks the counters.
// PFC pulse timing is checked on its own before the table runs.
`timescale 1ns/1ps

module tb_traffic_controller;

   import tc_cfg_pkg::*;
   import tc_stream_pkg::*;

   `include "tb_tc_vectors.svh"

   logic        tx_clk_156    = 1'b0;
   logic        tx_rst_n      = 1'b0;
   logic        tx_valid;
   eth_beat_t   tx_beat;
   logic        tx_ready      = 1'b0;
   logic        rx_valid      = 1'b0;
   eth_beat_t   rx_beat       = '0;
   logic [5:0]  rx_error      = '0;
   logic        rx_ready;
   logic        csr_read      = 1'b0;
   logic        csr_write     = 1'b0;
   csr_addr_t   csr_address   = '0;
   csr_data_t   csr_writedata = '0;
   csr_data_t   csr_readdata;
   logic        csr_ack;
   logic [1:0]  pause_data;
   logic [7:0]  pfc_pause_data;

   // Run state set by the main sequence
   int          run_id      = 0;
   pfc_prio_t   cur_class   = '0;
   beat_count_t cur_beats   = 8'd1;
   pkt_count_t  corrupt_pkt = 32'hFFFF_FFFF;

   // Stream monitor state
   int          seen_run     = 0;
   pkt_count_t  mon_pkt      = '0;
   beat_count_t mon_beat     = '0;
   int          beats_seen   = 0;
   int          paused_beats = 0; // Beats accepted while XOFF is high
   logic        prev_valid   = 1'b0;
   logic        prev_xfer    = 1'b0;
   logic        prev_hold    = 1'b0;

   int          err_main = 0;
   int          err_mon  = 0;

   traffic_controller_top dut0 (
      .tx_clk_156       (tx_clk_156),
      .tx_rst_n         (tx_rst_n),
      .o_tx_valid       (tx_valid),
      .o_tx_beat        (tx_beat),
      .i_tx_ready       (tx_ready),
      .i_rx_valid       (rx_valid),
      .i_rx_beat        (rx_beat),
      .i_rx_error       (rx_error),
      .o_rx_ready       (rx_ready),
      .i_csr_read       (csr_read),
      .i_csr_write      (csr_write),
      .i_csr_address    (csr_address),
      .i_csr_writedata  (csr_writedata),
      .o_csr_readdata   (csr_readdata),
      .o_csr_ack        (csr_ack),
      .o_pause_data     (pause_data),
      .o_pfc_pause_data (pfc_pause_data)
   );

   initial begin
      forever #2 tx_clk_156 = ~tx_clk_156; // 250 MHz
   end

   // ------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------
   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp, inout int errs);
      if (got !== exp) begin
         $display("Fail %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
         errs++;
      end
   endtask

   // One strobe, then wait for the ack
   task automatic csr_access(input logic wr, input csr_addr_t addr,
                             input csr_data_t wdata, output csr_data_t rdata);
      int n;
      @(posedge tx_clk_156);
      csr_read      <= !wr;
      csr_write     <= wr;
      csr_address   <= addr;
      csr_writedata <= wdata;
      n = 0;
      do begin
         @(posedge tx_clk_156);
         n++;
         csr_read  <= 1'b0;
         csr_write <= 1'b0;
      end while (!csr_ack && n < 8);
      rdata = csr_readdata;
      if (!csr_ack) begin
         $display("CSR access to address 0x%h was never acknowledged", addr);
         err_main++;
      end else begin
         check_value("o_csr_ack delay", 64'(n), 64'd2, err_main); // Ack in the next cycle
      end
   endtask

   task automatic csr_write_reg(input csr_addr_t addr, input csr_data_t wdata);
      csr_data_t unused;
      csr_access(1'b1, addr, wdata, unused);
   endtask

   task automatic csr_read_reg(input csr_addr_t addr, output csr_data_t rdata);
      csr_access(1'b0, addr, '0, rdata);
   endtask

   task automatic expect_reg(input string name, input csr_addr_t addr, input csr_data_t exp);
      csr_data_t rd;
      csr_read_reg(addr, rd);
      check_value(name, 64'(rd), 64'(exp), err_main);
   endtask

   function automatic int watchdog_cycles();
      int total;
      total = 4000;
      for (int v = 0; v < NUM_VECTORS; v++)
         total += 4 * int'(VECTORS[v].pkt_count) * (int'(VECTORS[v].beats) + 1)
                  + int'(VECTORS[v].quanta) + 400;
      return total;
   endfunction

   // ------------------------------------------------------------------
   // PFC checks
   // ------------------------------------------------------------------
   task automatic pfc_pulse_check(input pfc_prio_t prio, input pfc_quanta_t q);
      int high;
      csr_write_reg(REG_PFC_QUANTA_BASE + 16'(prio), 32'(q));
      check_value("o_pfc_pause_data before rise", 64'(pfc_pause_data), 64'd0, err_main);
      high = 0;
      @(posedge tx_clk_156);
      while (pfc_pause_data[prio] && high < int'(q) + 8) begin
         check_value("o_pause_data during pause", 64'(pause_data), 64'h1, err_main);
         high++;
         @(posedge tx_clk_156);
      end
      check_value("pfc pause length", 64'(high), 64'(q), err_main);
      check_value("o_pause_data at release", 64'(pause_data), 64'h2, err_main); // XON
      @(posedge tx_clk_156);
      check_value("o_pause_data after release", 64'(pause_data), 64'h0, err_main);
      expect_reg("quanta readback", REG_PFC_QUANTA_BASE + 16'(prio), 32'(q));
   endtask

   // Quanta 0 cuts a running pause short
   task automatic pfc_stop_check(input pfc_prio_t prio);
      csr_write_reg(REG_PFC_QUANTA_BASE + 16'(prio), 32'd200);
      @(posedge tx_clk_156);
      check_value("pfc bit before stop", 64'(pfc_pause_data[prio]), 64'd1, err_main);
      csr_write_reg(REG_PFC_QUANTA_BASE + 16'(prio), 32'd0);
      @(posedge tx_clk_156);
      check_value("o_pfc_pause_data after stop", 64'(pfc_pause_data), 64'd0, err_main);
      check_value("o_pause_data after stop", 64'(pause_data), 64'h2, err_main);
   endtask

   // ------------------------------------------------------------------
   // Table entry
   // ------------------------------------------------------------------
   task automatic run_vector(input vector_entry_t vec);
      csr_data_t rd;
      csr_data_t good;
      csr_data_t bad;
      int        n;
      csr_write_reg(REG_CTRL, 32'h2);
      expect_reg("REG_STAT_TX after clear", REG_STAT_TX, '0);
      expect_reg("REG_STAT_RX_GOOD after clear", REG_STAT_RX_GOOD, '0);
      expect_reg("REG_STAT_RX_BAD after clear", REG_STAT_RX_BAD, '0);
      csr_write_reg(REG_PKT_COUNT, vec.pkt_count);
      expect_reg("REG_PKT_COUNT", REG_PKT_COUNT, vec.pkt_count);
      csr_write_reg(REG_PKT_BEATS, 32'(vec.beats));
      expect_reg("REG_PKT_BEATS", REG_PKT_BEATS, 32'(vec.beats));
      csr_write_reg(REG_TX_CLASS, 32'(vec.cls));
      expect_reg("REG_TX_CLASS", REG_TX_CLASS, 32'(vec.cls));
      cur_class   <= vec.cls;
      cur_beats   <= vec.beats;
      corrupt_pkt <= vec.corrupt_pkt;
      run_id      <= run_id + 1;
      if (vec.quanta != '0)
         csr_write_reg(REG_PFC_QUANTA_BASE + 16'(vec.pause_prio), 32'(vec.quanta));
      csr_write_reg(REG_CTRL, 32'h1);

      n = 0;
      do begin
         csr_read_reg(REG_STATUS, rd);
         n++;
      end while (rd[STATUS_BUSY_BIT] && n < 2000);
      if (rd[STATUS_BUSY_BIT]) begin
         $display("Generator still busy after %0d status reads", n);
         err_main++;
      end

      // Checker results trail the last beat by a few cycles
      n = 0;
      do begin
         csr_read_reg(REG_STAT_RX_GOOD, good);
         csr_read_reg(REG_STAT_RX_BAD, bad);
         n++;
      end while (good + bad != vec.pkt_count && n < 100);

      expect_reg("REG_STAT_TX", REG_STAT_TX, vec.pkt_count);
      check_value("REG_STAT_RX_GOOD", 64'(good), 64'(vec.exp_good), err_main);
      check_value("REG_STAT_RX_BAD", 64'(bad), 64'(vec.exp_bad), err_main);
      check_value("beats seen on TX", 64'(beats_seen),
                  64'(int'(vec.pkt_count) * int'(vec.beats)), err_main);
      if (vec.quanta != '0 && vec.pause_prio != vec.cls)
         check_value("traffic during other class pause", 64'(paused_beats != 0), 64'd1,
                     err_main);
   endtask

   // ------------------------------------------------------------------
   // Stimulus processes
   // ------------------------------------------------------------------
   initial begin : ready_gen
      void'($urandom(32'h6e56_e886));
      forever begin
         @(posedge tx_clk_156);
         tx_ready <= ($urandom % 4) != 0; // About 75 % ready
      end
   end

   always @(posedge tx_clk_156) begin : loopback
      eth_beat_t beat;
      beat = tx_beat;
      if (tx_beat.sop && tx_beat.data[63:32] == corrupt_pkt)
         beat.data[0] = ~beat.data[0];
      rx_valid <= tx_valid && tx_ready;
      rx_beat  <= beat;
   end

   // Payload rule and class hold as seen on the TX port
   always @(posedge tx_clk_156) begin : tx_monitor
      logic xfer;
      logic last;
      xfer = tx_valid && tx_ready;
      last = (mon_beat == cur_beats - 8'd1);
      if (run_id != seen_run) begin
         seen_run     = run_id;
         mon_pkt      = '0;
         mon_beat     = '0;
         beats_seen   = 0;
         paused_beats = 0;
      end
      if (tx_rst_n)
         check_value("o_rx_ready", 64'(rx_ready), 64'd1, err_mon); // Checker never stalls
      if (tx_rst_n && tx_valid && (!prev_valid || prev_xfer))
         check_value("class pause at new beat", 64'(prev_hold), 64'd0, err_mon);
      if (tx_rst_n && xfer) begin
         check_value("o_tx_beat.data", tx_beat.data, {mon_pkt, 24'd0, mon_beat}, err_mon);
         check_value("o_tx_beat.sop", 64'(tx_beat.sop), 64'(mon_beat == 8'd0), err_mon);
         check_value("o_tx_beat.eop", 64'(tx_beat.eop), 64'(last), err_mon);
         check_value("o_tx_beat.empty", 64'(tx_beat.empty), 64'd0, err_mon);
         check_value("o_tx_beat.error", 64'(tx_beat.error), 64'd0, err_mon);
         beats_seen++;
         if (pause_data[0])
            paused_beats++;
         if (last) begin
            mon_beat = '0;
            mon_pkt++;
         end else begin
            mon_beat++;
         end
      end
      prev_valid = tx_valid;
      prev_xfer  = xfer;
      prev_hold  = pfc_pause_data[cur_class];
   end

   initial begin : watchdog
      int limit;
      limit = watchdog_cycles();
      repeat (limit) @(posedge tx_clk_156);
      $display("Watchdog expired, run did not finish within %0d cycles", limit);
      $display("Testbench failed");
      $finish;
   end

   // ------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------
   initial begin : main
      repeat (16) @(posedge tx_clk_156);
      tx_rst_n <= 1'b1;
      @(posedge tx_clk_156);
      check_value("o_tx_valid after reset", 64'(tx_valid), 64'd0, err_main);
      check_value("o_csr_ack after reset", 64'(csr_ack), 64'd0, err_main);
      check_value("o_pause_data after reset", 64'(pause_data), 64'd0, err_main);
      check_value("o_pfc_pause_data after reset", 64'(pfc_pause_data), 64'd0, err_main);
      expect_reg("REG_STATUS after reset", REG_STATUS, '0);
      expect_reg("unmapped 0x0008", 16'h0008, '0);
      expect_reg("unmapped 0x0100", 16'h0100, '0);
      csr_write_reg(16'h0009, 32'hDEAD_BEEF);
      expect_reg("unmapped 0x0009 after write", 16'h0009, '0);

      pfc_pulse_check(3'd4, 16'd25);
      pfc_pulse_check(3'd0, 16'd1);
      pfc_stop_check(3'd6);

      for (int v = 0; v < NUM_VECTORS; v++)
         run_vector(VECTORS[v]);

      $display("Errors: %0d in sequence checks, %0d in stream checks", err_main, err_mon);
      if (err_main + err_mon == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule
